//--- exec_units.sv
/* Single-cycle ALU and MUL_STAGES-deep multiplier sharing one CDB.
   Multiply always wins; rs must honour alu_open or an ALU result collides */
`timescale 1ns/1ps
`include "tomasulo_defs.svh"

module exec_units import tomasulo_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    issue_if.unit alu_iss,
    issue_if.unit mul_iss,
    output logic  alu_open,
    cdb_if.bus    cdb
);

    localparam int L = `MUL_STAGES - 1;  // Last multiplier stage

    logic     alu_q_valid;
    tag_t     alu_q_tag;
    reg_idx_t alu_q_rd;
    word_t    alu_q_value;
    word_t    alu_result;

    logic [L:0] m_valid;
    tag_t       m_tag  [`MUL_STAGES];
    reg_idx_t   m_rd   [`MUL_STAGES];
    word_t      m_data [`MUL_STAGES];

    always_comb begin
        case (alu_iss.op)
            `OP_LI:  alu_result = alu_iss.a;  // Immediate rides in operand a
            `OP_ADD: alu_result = alu_iss.a + alu_iss.b;
            `OP_SUB: alu_result = alu_iss.a - alu_iss.b;
            `OP_AND: alu_result = alu_iss.a & alu_iss.b;
            default: alu_result = '0;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            alu_q_valid <= 1'b0;
            m_valid     <= '0;
        end else begin
            alu_q_valid <= alu_iss.valid;
            m_valid     <= {m_valid[L-1:0], mul_iss.valid};  // Shift toward the CDB
        end
    end

    always_ff @(posedge clock) begin
        if (alu_iss.valid) begin
            alu_q_tag   <= alu_iss.tag;
            alu_q_rd    <= alu_iss.rd;
            alu_q_value <= alu_result;
        end
        m_tag[0]  <= mul_iss.tag;
        m_rd[0]   <= mul_iss.rd;
        m_data[0] <= mul_iss.a * mul_iss.b;  // Low XLEN bits kept
        for (int s = 1; s <= L; s++) begin
            m_tag[s]  <= m_tag[s-1];
            m_rd[s]   <= m_rd[s-1];
            m_data[s] <= m_data[s-1];
        end
    end

    assign alu_open = !m_valid[L-1];  // Product lands on the CDB next cycle

    always_comb begin
        if (m_valid[L]) begin
            cdb.valid = 1'b1;
            cdb.tag   = m_tag[L];
            cdb.rd    = m_rd[L];
            cdb.value = m_data[L];
        end else begin
            cdb.valid = alu_q_valid;
            cdb.tag   = alu_q_tag;
            cdb.rd    = alu_q_rd;
            cdb.value = alu_q_value;
        end
    end

endmodule

//--- map_table.sv
/* Register values and producer tags; r0 reads zero and is never renamed.
   Sources whose producer broadcasts in the dispatch cycle come straight off the CDB */
`timescale 1ns/1ps
`include "tomasulo_defs.svh"

module map_table import tomasulo_pkg::*; (
    input  logic          clock,
    input  logic          reset,
    input  logic          disp_valid,
    input  op_t           disp_op,
    input  reg_idx_t      disp_rd,
    input  reg_idx_t      disp_rs1,
    input  reg_idx_t      disp_rs2,
    input  word_t         disp_imm,
    rs_dispatch_if.rename dsp,
    cdb_if.listen         cdb
);

    word_t value [`NUM_REGS];  // Committed register values
    tag_t  tag   [`NUM_REGS];  // Pending producer, 0 when value is current

    tag_t  raw_t1, raw_t2;

    always_comb begin
        dsp.valid = disp_valid;
        dsp.op    = disp_op;
        dsp.rd    = disp_rd;
        dsp.imm   = disp_imm;
        raw_t1    = tag[disp_rs1];
        raw_t2    = tag[disp_rs2];
        // Bypass a producer finishing right now
        if (cdb.valid && raw_t1 != '0 && raw_t1 == cdb.tag) begin
            dsp.v1 = cdb.value;
            dsp.t1 = '0;
        end else begin
            dsp.v1 = value[disp_rs1];
            dsp.t1 = raw_t1;
        end
        if (cdb.valid && raw_t2 != '0 && raw_t2 == cdb.tag) begin
            dsp.v2 = cdb.value;
            dsp.t2 = '0;
        end else begin
            dsp.v2 = value[disp_rs2];
            dsp.t2 = raw_t2;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                value[i] <= '0;
                tag[i]   <= '0;
            end
        end else begin
            for (int i = 1; i < `NUM_REGS; i++) begin  // r0 skipped
                if (cdb.valid && tag[i] != '0 && tag[i] == cdb.tag) begin
                    value[i] <= cdb.value;
                    tag[i]   <= '0;  // Result now architectural
                end
            end
            // Later assignment, so a same-cycle rename keeps the new tag
            if (disp_valid && dsp.alloc_tag != '0 && disp_rd != '0)
                tag[disp_rd] <= dsp.alloc_tag;
        end
    end

endmodule

//--- rs.sv
/* Four-entry station, entries 1-2 ALU and 3-4 multiply, tag equals entry index.
   LI ignores its sources and carries the immediate as operand a */
`timescale 1ns/1ps
`include "tomasulo_defs.svh"

module rs import tomasulo_pkg::*; (
    input  logic           clock,
    input  logic           reset,
    rs_dispatch_if.station dsp,
    cdb_if.listen          cdb,
    input  logic           alu_open,   // Low while a multiply claims the next CDB slot
    issue_if.station       alu_iss,
    issue_if.station       mul_iss,
    output logic           alu_avail,
    output logic           mult_avail
);

    localparam int N = `NUM_RS;

    logic [N:1] busy;
    logic [N:1] issued;
    logic [N:1] v1_ok;
    logic [N:1] v2_ok;
    tag_t       t1 [1:N];
    tag_t       t2 [1:N];
    op_t        op [1:N];
    reg_idx_t   rd [1:N];
    word_t      v1 [1:N];
    word_t      v2 [1:N];

    logic [N:1] free_e;    // Own tag on the CDB this cycle
    logic [N:1] open_e;    // Allocatable this cycle
    logic [N:1] ready_e;   // Both operands in, not yet sent
    logic [N:1] wake1, wake2;
    tag_t       alloc_tag;
    tag_t       alu_sel, mul_sel;  // 0 means nothing issues
    cls_t       d_cls;
    logic       is_li;

    // Class is fixed by position
    function automatic cls_t entry_cls(input int i);
        return (i > N / 2) ? `CLS_MULT : `CLS_ALU;
    endfunction

    always_comb begin
        d_cls      = (dsp.op == `OP_MUL) ? `CLS_MULT : `CLS_ALU;
        is_li      = (dsp.op == `OP_LI);
        alloc_tag  = '0;
        alu_avail  = 1'b0;
        mult_avail = 1'b0;
        for (int i = N; i >= 1; i--) begin  // Walk down so the lowest index wins
            free_e[i]  = busy[i] && cdb.valid && (cdb.tag == tag_t'(i));
            open_e[i]  = !busy[i] || free_e[i];
            ready_e[i] = busy[i] && !issued[i] && v1_ok[i] && v2_ok[i];
            wake1[i]   = busy[i] && !v1_ok[i] && cdb.valid && (cdb.tag == t1[i]);
            wake2[i]   = busy[i] && !v2_ok[i] && cdb.valid && (cdb.tag == t2[i]);
            if (open_e[i]) begin
                if (entry_cls(i) == `CLS_ALU)
                    alu_avail = 1'b1;
                else
                    mult_avail = 1'b1;
                if (dsp.valid && entry_cls(i) == d_cls)
                    alloc_tag = tag_t'(i);
            end
        end
        dsp.alloc_tag = alloc_tag;
    end

    // Issue select, lowest ready per class
    always_comb begin
        alu_sel = '0;
        mul_sel = '0;
        for (int i = N; i >= 1; i--) begin
            if (ready_e[i]) begin
                if (entry_cls(i) == `CLS_ALU)
                    alu_sel = tag_t'(i);
                else
                    mul_sel = tag_t'(i);
            end
        end
        if (!alu_open)
            alu_sel = '0;  // Hold ALU off, multiply owns that CDB slot
    end

    always_comb begin
        alu_iss.valid = (alu_sel != '0);
        alu_iss.tag   = alu_sel;
        alu_iss.op    = '0;
        alu_iss.a     = '0;
        alu_iss.b     = '0;
        alu_iss.rd    = '0;
        mul_iss.valid = (mul_sel != '0);
        mul_iss.tag   = mul_sel;
        mul_iss.op    = '0;
        mul_iss.a     = '0;
        mul_iss.b     = '0;
        mul_iss.rd    = '0;
        for (int i = 1; i <= N; i++) begin
            if (alu_sel == tag_t'(i)) begin
                alu_iss.op = op[i];
                alu_iss.a  = v1[i];
                alu_iss.b  = v2[i];
                alu_iss.rd = rd[i];
            end
            if (mul_sel == tag_t'(i)) begin
                mul_iss.op = op[i];
                mul_iss.a  = v1[i];
                mul_iss.b  = v2[i];
                mul_iss.rd = rd[i];
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy   <= '0;
            issued <= '0;
            v1_ok  <= '0;
            v2_ok  <= '0;
            for (int i = 1; i <= N; i++) begin
                t1[i] <= '0;
                t2[i] <= '0;
            end
        end else begin
            for (int i = 1; i <= N; i++) begin
                if (free_e[i])
                    busy[i] <= 1'b0;
                if (alu_sel == tag_t'(i) || mul_sel == tag_t'(i))
                    issued[i] <= 1'b1;
                if (wake1[i]) begin
                    v1_ok[i] <= 1'b1;
                    t1[i]    <= '0;
                end
                if (wake2[i]) begin
                    v2_ok[i] <= 1'b1;
                    t2[i]    <= '0;
                end
                if (alloc_tag == tag_t'(i)) begin  // Overrides the freeing above
                    busy[i]   <= 1'b1;
                    issued[i] <= 1'b0;
                    t1[i]     <= is_li ? '0 : dsp.t1;
                    t2[i]     <= is_li ? '0 : dsp.t2;
                    v1_ok[i]  <= is_li || (dsp.t1 == '0);
                    v2_ok[i]  <= is_li || (dsp.t2 == '0);
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 1; i <= N; i++) begin
            if (alloc_tag == tag_t'(i)) begin
                op[i] <= dsp.op;
                rd[i] <= dsp.rd;
                v1[i] <= is_li ? dsp.imm : dsp.v1;
                v2[i] <= dsp.v2;
            end else begin
                if (wake1[i])
                    v1[i] <= cdb.value;
                if (wake2[i])
                    v2[i] <= cdb.value;
            end
        end
    end

endmodule

//--- run.sh
#!/bin/bash
# Build and run the testbench with Verilator, then search the log for failure
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f tomasulo.f --top-module tomasulo_tb -o tomasulo_sim
./obj_dir/tomasulo_sim | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
exit 0

//--- tomasulo.f
+incdir+.
tomasulo_pkg.sv
tomasulo_if.sv
map_table.sv
rs.sv
exec_units.sv
tomasulo_core.sv
tomasulo_sva.sv
tomasulo_tb.sv

//--- tomasulo_core.sv
/* Core top; a dispatch for a class whose avail is low is dropped with disp_tag 0.
   Results come out of order, cdb_valid marks each one */
`timescale 1ns/1ps

module tomasulo_core import tomasulo_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     disp_valid,
    input  op_t      disp_op,
    input  reg_idx_t disp_rd,
    input  reg_idx_t disp_rs1,
    input  reg_idx_t disp_rs2,
    input  word_t    disp_imm,
    output logic     alu_avail,
    output logic     mult_avail,
    output tag_t     disp_tag,
    output logic     cdb_valid,
    output tag_t     cdb_tag,
    output reg_idx_t cdb_rd,
    output word_t    cdb_value
);

    logic alu_open;

    rs_dispatch_if dsp ();
    issue_if       alu_iss ();
    issue_if       mul_iss ();
    cdb_if         cdb ();

    map_table u_map (
        .clock     (clock),
        .reset     (reset),
        .disp_valid(disp_valid),
        .disp_op   (disp_op),
        .disp_rd   (disp_rd),
        .disp_rs1  (disp_rs1),
        .disp_rs2  (disp_rs2),
        .disp_imm  (disp_imm),
        .dsp       (dsp.rename),
        .cdb       (cdb.listen)
    );

    rs u_rs (
        .clock     (clock),
        .reset     (reset),
        .dsp       (dsp.station),
        .cdb       (cdb.listen),
        .alu_open  (alu_open),
        .alu_iss   (alu_iss.station),
        .mul_iss   (mul_iss.station),
        .alu_avail (alu_avail),
        .mult_avail(mult_avail)
    );

    exec_units u_exec (
        .clock   (clock),
        .reset   (reset),
        .alu_iss (alu_iss.unit),
        .mul_iss (mul_iss.unit),
        .alu_open(alu_open),
        .cdb     (cdb.bus)
    );

    // Plain outputs straight off the internal buses
    assign disp_tag  = dsp.alloc_tag;
    assign cdb_valid = cdb.valid;
    assign cdb_tag   = cdb.tag;
    assign cdb_rd    = cdb.rd;
    assign cdb_value = cdb.value;

endmodule

//--- tomasulo_defs.svh
/* Core sizes and encodings; tag 0 is reserved as "no producer", so tags run 1..NUM_RS */
`ifndef TOMASULO_DEFS_SVH
`define TOMASULO_DEFS_SVH

`define XLEN       32
`define NUM_REGS   8    // r0 hardwired to zero
`define NUM_RS     4    // Lower half ALU class, upper half multiply class
`define TAG_W      3    // Holds 0..NUM_RS
`define MUL_STAGES 3

// Operation codes
`define OP_LI  3'd0
`define OP_ADD 3'd1
`define OP_SUB 3'd2
`define OP_AND 3'd3
`define OP_MUL 3'd4

// Unit classes
`define CLS_ALU  1'b0
`define CLS_MULT 1'b1

`endif

//--- tomasulo_if.sv
/* Internal buses of the core; every valid is a one-cycle strobe with no back-pressure */
`timescale 1ns/1ps

// Renamed instruction from the map table into the station
interface rs_dispatch_if import tomasulo_pkg::*; ();
    logic     valid;      // Raw strobe, station decides acceptance
    op_t      op;
    reg_idx_t rd;
    word_t    imm;
    word_t    v1;
    tag_t     t1;         // 0 when v1 already holds the value
    word_t    v2;
    tag_t     t2;
    tag_t     alloc_tag;  // Entry taken, 0 if class full or no strobe

    modport rename  (output valid, op, rd, imm, v1, t1, v2, t2, input alloc_tag);
    modport station (input valid, op, rd, imm, v1, t1, v2, t2, output alloc_tag);
endinterface

// One issue port per unit class
interface issue_if import tomasulo_pkg::*; ();
    logic     valid;
    op_t      op;
    word_t    a;
    word_t    b;
    tag_t     tag;
    reg_idx_t rd;

    modport station (output valid, op, a, b, tag, rd);
    modport unit    (input valid, op, a, b, tag, rd);
endinterface

// Common data bus, one broadcast per cycle
interface cdb_if import tomasulo_pkg::*; ();
    logic     valid;
    tag_t     tag;
    reg_idx_t rd;
    word_t    value;

    modport bus    (output valid, tag, rd, value);
    modport listen (input valid, tag, rd, value);
endinterface

//--- tomasulo_pkg.sv
/* Vector types shared by the core; a tag_t of 0 always marks a ready operand */
`include "tomasulo_defs.svh"

package tomasulo_pkg;

    typedef logic [`XLEN-1:0]             word_t;     // Data word
    typedef logic [`TAG_W-1:0]            tag_t;      // Station index of the producer
    typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;  // Architectural register
    typedef logic [2:0]                   op_t;       // One of the OP_* codes
    typedef logic [0:0]                   cls_t;      // ALU or multiply

endpackage

//--- tomasulo_sva.sv
/* Station and CDB checks, bound into rs; tags above NUM_RS never reach the selectors */
`timescale 1ns/1ps
`include "tomasulo_defs.svh"

module tomasulo_sva import tomasulo_pkg::*; (
    input logic clock,
    input logic reset,
    input tag_t alu_sel,
    input tag_t mul_sel,
    input tag_t t1 [1:`NUM_RS],
    input tag_t t2 [1:`NUM_RS],
    input logic cdb_valid,
    input tag_t cdb_tag
);

    // Issued entry has no producer left on either source
    alu_issue_ready: assert property (@(posedge clock) disable iff (reset)
        alu_sel != '0 |-> t1[alu_sel] == '0 && t2[alu_sel] == '0)
        else $error("ALU issue from entry %0d with a pending source", alu_sel);

    mul_issue_ready: assert property (@(posedge clock) disable iff (reset)
        mul_sel != '0 |-> t1[mul_sel] == '0 && t2[mul_sel] == '0)
        else $error("Multiply issue from entry %0d with a pending source", mul_sel);

    // ALU result owns the CDB one cycle after issue
    alu_result_kept: assert property (@(posedge clock) disable iff (reset)
        alu_sel != '0 |=> cdb_valid && cdb_tag == $past(alu_sel))
        else $error("ALU result missing from the CDB after issue");

    cdb_tag_nonzero: assert property (@(posedge clock) disable iff (reset)
        cdb_valid |-> cdb_tag != '0)
        else $error("CDB valid with tag 0");

endmodule

bind rs tomasulo_sva u_sva (
    .clock    (clock),
    .reset    (reset),
    .alu_sel  (alu_sel),
    .mul_sel  (mul_sel),
    .t1       (t1),
    .t2       (t2),
    .cdb_valid(cdb.valid),
    .cdb_tag  (cdb.tag)
);

//--- tomasulo_tb.sv
/* Table-driven testbench with a sequential register model; one result per tag.
   Inputs change on the falling edge, CDB is sampled there too */
`timescale 1ns/1ps
`include "tomasulo_defs.svh"

module tomasulo_tb import tomasulo_pkg::*; ();

    localparam int MAX_ROWS = 64;
    localparam int LIMIT    = 60;  // Cycles allowed per wait

    logic     clock, reset, disp_valid;
    op_t      disp_op;
    reg_idx_t disp_rd, disp_rs1, disp_rs2;
    word_t    disp_imm;
    logic     alu_avail, mult_avail, cdb_valid;
    tag_t     disp_tag, cdb_tag;
    reg_idx_t cdb_rd;
    word_t    cdb_value;

    op_t      t_op   [MAX_ROWS];  // Stimulus table
    reg_idx_t t_rd   [MAX_ROWS];
    reg_idx_t t_rs1  [MAX_ROWS];
    reg_idx_t t_rs2  [MAX_ROWS];
    word_t    t_imm  [MAX_ROWS];
    logic     t_drop [MAX_ROWS];  // Class expected full, strobe must be ignored
    int       t_test [MAX_ROWS];
    int       n_rows;

    word_t    model [`NUM_REGS];  // Program-order register state
    logic     pend_valid [1:`NUM_RS];
    reg_idx_t pend_rd    [1:`NUM_RS];
    word_t    pend_value [1:`NUM_RS];
    int       pend_count, errors, broadcasts, passed, failed, err_before;
    integer   seed;
    string    names [1:6];

    tomasulo_core UUT (
        .clock(clock), .reset(reset), .disp_valid(disp_valid), .disp_op(disp_op),
        .disp_rd(disp_rd), .disp_rs1(disp_rs1), .disp_rs2(disp_rs2), .disp_imm(disp_imm),
        .alu_avail(alu_avail), .mult_avail(mult_avail), .disp_tag(disp_tag),
        .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_rd(cdb_rd), .cdb_value(cdb_value)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    function automatic word_t expected_result(op_t op, word_t a, word_t b, word_t imm);
        case (op)
            `OP_LI:  return imm;
            `OP_ADD: return a + b;
            `OP_SUB: return a - b;
            `OP_AND: return a & b;
            `OP_MUL: return a * b;  // Low 32 bits
            default: return '0;
        endcase
    endfunction

    task automatic add_row(op_t op, int rd, int rs1, int rs2, word_t imm, logic drop, int test);
        t_op[n_rows]   = op;
        t_rd[n_rows]   = reg_idx_t'(rd);
        t_rs1[n_rows]  = reg_idx_t'(rs1);
        t_rs2[n_rows]  = reg_idx_t'(rs2);
        t_imm[n_rows]  = imm;
        t_drop[n_rows] = drop;
        t_test[n_rows] = test;
        n_rows++;
    endtask

    task automatic abort_run(string what);
        $display("Timeout while waiting for %s at %0t", what, $time);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    // Every broadcast must retire exactly one outstanding tag
    always @(negedge clock) begin
        if (!reset && cdb_valid) begin
            broadcasts++;
            if (cdb_tag == '0 || int'(cdb_tag) > `NUM_RS || !pend_valid[cdb_tag]) begin
                $display("Broadcast at %0t carries tag %0d with nothing outstanding",
                         $time, cdb_tag);
                errors++;
            end else begin
                if (cdb_rd !== pend_rd[cdb_tag]) begin
                    $display("** Error at %0t: cdb_rd = %0d, expected %0d",
                             $time, cdb_rd, pend_rd[cdb_tag]);
                    errors++;
                end
                if (cdb_value !== pend_value[cdb_tag]) begin
                    $display("** Error at %0t: cdb_value = %h, expected %h",
                             $time, cdb_value, pend_value[cdb_tag]);
                    errors++;
                end
                pend_valid[cdb_tag] = 1'b0;
                pend_count--;
            end
        end
    end

    // Starts and ends on a falling edge
    task automatic apply_row(int i);
        int    waited;
        logic  avail;
        word_t result;
        waited = 0;
        avail  = (t_op[i] == `OP_MUL) ? mult_avail : alu_avail;
        while (!t_drop[i] && !avail) begin
            disp_valid = 1'b0;
            @(negedge clock);
            waited++;
            if (waited > LIMIT)
                abort_run("class availability");
            avail = (t_op[i] == `OP_MUL) ? mult_avail : alu_avail;
        end
        if (t_drop[i] && avail) begin
            $display("Row %0d: class still available while its entries should be full", i);
            errors++;
        end
        disp_op    = t_op[i];
        disp_rd    = t_rd[i];
        disp_rs1   = t_rs1[i];
        disp_rs2   = t_rs2[i];
        disp_imm   = t_imm[i];
        disp_valid = 1'b1;
        #10;
        if (t_drop[i]) begin
            if (disp_tag !== '0) begin
                $display("** Error at %0t: disp_tag = %0d, expected 0", $time, disp_tag);
                errors++;
            end
        end else if (disp_tag == '0 || int'(disp_tag) > `NUM_RS) begin
            $display("Row %0d was refused or got tag %0d at %0t", i, disp_tag, $time);
            errors++;
        end else begin
            result = expected_result(t_op[i], model[t_rs1[i]], model[t_rs2[i]], t_imm[i]);
            if (pend_valid[disp_tag]) begin
                $display("Row %0d got tag %0d that is still outstanding", i, disp_tag);
                errors++;
            end else begin
                pend_count++;
            end
            pend_valid[disp_tag] = 1'b1;
            pend_rd[disp_tag]    = t_rd[i];
            pend_value[disp_tag] = result;
            if (t_rd[i] != '0)
                model[t_rd[i]] = result;  // r0 stays zero
        end
        @(negedge clock);
        disp_valid = 1'b0;
    endtask

    task automatic drain;
        int waited;
        waited = 0;
        while (pend_count != 0) begin
            @(posedge clock);
            waited++;
            if (waited > LIMIT)
                abort_run("outstanding broadcasts");
        end
        @(negedge clock);
        if (!alu_avail || !mult_avail) begin
            $display("Entries still busy at %0t after every result was broadcast", $time);
            errors++;
        end
    endtask

    initial begin
        seed       = 33961;
        reset      = 1'b1;
        disp_valid = 1'b0;
        disp_op    = '0;
        disp_rd    = '0;
        disp_rs1   = '0;
        disp_rs2   = '0;
        disp_imm   = '0;
        errors     = 0;
        broadcasts = 0;
        pend_count = 0;
        passed     = 0;
        failed     = 0;
        n_rows     = 0;
        for (int r = 0; r < `NUM_REGS; r++)
            model[r] = '0;
        for (int t = 1; t <= `NUM_RS; t++)
            pend_valid[t] = 1'b0;
        names = '{"reset state", "ALU ops", "RAW chain", "multiply pipeline",
                  "full ALU class", "random rows"};

        add_row(`OP_LI, 1, 0, 0, 32'd7, 1'b0, 2);
        add_row(`OP_LI, 2, 0, 0, 32'd3, 1'b0, 2);
        add_row(`OP_LI, 3, 0, 0, 32'h0ff0, 1'b0, 2);
        add_row(`OP_ADD, 4, 1, 2, '0, 1'b0, 2);
        add_row(`OP_SUB, 5, 2, 1, '0, 1'b0, 2);
        add_row(`OP_AND, 6, 3, 4, '0, 1'b0, 2);
        add_row(`OP_LI, 1, 0, 0, 32'd5, 1'b0, 3);   // LI -> MUL -> ADD -> SUB -> AND
        add_row(`OP_MUL, 2, 1, 1, '0, 1'b0, 3);
        add_row(`OP_ADD, 3, 2, 1, '0, 1'b0, 3);
        add_row(`OP_SUB, 4, 3, 2, '0, 1'b0, 3);
        add_row(`OP_AND, 5, 4, 3, '0, 1'b0, 3);
        add_row(`OP_MUL, 6, 1, 2, '0, 1'b0, 4);
        add_row(`OP_ADD, 7, 1, 1, '0, 1'b0, 4);
        add_row(`OP_MUL, 6, 6, 2, '0, 1'b0, 4);
        add_row(`OP_SUB, 3, 2, 1, '0, 1'b0, 4);
        add_row(`OP_MUL, 4, 1, 3, '0, 1'b0, 4);
        add_row(`OP_ADD, 5, 6, 4, '0, 1'b0, 4);
        add_row(`OP_MUL, 5, 1, 2, '0, 1'b0, 5);     // Both ALU entries wait on this
        add_row(`OP_ADD, 6, 5, 1, '0, 1'b0, 5);
        add_row(`OP_SUB, 7, 5, 2, '0, 1'b0, 5);
        add_row(`OP_AND, 3, 1, 2, '0, 1'b1, 5);     // Dropped strobe
        for (int k = 0; k < 40; k++)               // Few registers, so WAW is common
            add_row(op_t'($unsigned($random(seed)) % 5), $unsigned($random(seed)) % 5,
                    $unsigned($random(seed)) % 5, $unsigned($random(seed)) % 5,
                    $random(seed), 1'b0, 6);

        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        err_before = errors;
        @(negedge clock);
        if (!alu_avail || !mult_avail) begin
            $display("Classes not available after reset");
            errors++;
        end
        repeat (5) begin
            if (cdb_valid) begin
                $display("cdb_valid high at %0t with nothing dispatched", $time);
                errors++;
            end
            @(negedge clock);
        end
        for (int t = 1; t <= 6; t++) begin
            if (t > 1) begin
                err_before = errors;
                for (int i = 0; i < n_rows; i++)
                    if (t_test[i] == t)
                        apply_row(i);
                drain();
            end
            if (errors == err_before) begin
                passed++;
                $display("Test %0d %s: ok", t, names[t]);
            end else begin
                failed++;
                $display("Test %0d %s: failed with %0d errors", t, names[t], errors - err_before);
            end
        end

        $display("Tests passed %0d, failed %0d, broadcasts checked %0d, errors %0d",
                 passed, failed, broadcasts, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
